// File: Bender.yml
package:
  name: smc

sources:
  - include_dirs:
      - include
    files:
      - hw/smc_pkg.sv
      - hw/smc_ahb_if.sv
      - hw/smc_cfg_regs.sv
      - hw/smc_mac.sv
      - hw/smc_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/smc_sram_model.sv
      - tb/smc_checker.sv
      - tb/tb_smc.sv

// File: hw/smc_ahb_if.sv
// AHB-lite slave front end; decodes and checks each address phase and drives the bus response
`timescale 1ns/1ps
`default_nettype none

`include "smc_config.svh"

module smc_ahb_if (
  input  logic              hclk6,
  input  logic              n_sys_reset6,
  input  logic              hsel,
  input  logic [31:0]       haddr,
  input  smc_pkg::htrans_e  htrans,
  input  logic              hwrite,
  input  smc_pkg::hsize_e   hsize,
  input  logic              hready,      // Muxed bus ready
  input  logic              mem_en,
  input  logic              smc_done,    // Last hold cycle of a transfer
  input  logic              mac_done,    // Last transfer of the access
  input  logic [31:0]       read_data,
  input  logic [31:0]       cfg_rdata,
  output logic [31:0]       smc_hrdata,
  output logic              smc_hready,
  output smc_pkg::hresp_e   smc_hresp,
  output logic              smc_valid,
  output logic              new_access,  // Starts the access FSM
  output logic              cfg_access,  // Config data phase
  output smc_pkg::ahb_req_t req
);
  import smc_pkg::*;

  logic acc_req;    // Selected real transfer, address accepted
  logic cfg_sel;    // Address lands in config space
  logic mis_err;    // Misaligned halfword or word
  logic dis_err;    // SRAM space while disabled
  logic r_ready;    // Registered part of smc_hready
  logic r_hresp;    // Second cycle of ERROR pending

  // ------------------------------
  // Address phase decode
  // ------------------------------
  assign acc_req = hsel & hready & ((htrans == TRN_NONSEQ) | (htrans == TRN_SEQ));
  assign cfg_sel = haddr[`SMC_CFG_SEL_BIT];

  // Byte never misaligned
  assign mis_err = acc_req & (((hsize == SZ_HALF) & haddr[0]) |
                              ((hsize == SZ_WORD) & (haddr[1:0] != 2'b00)));
  assign dis_err = acc_req & ~mis_err & ~cfg_sel & ~mem_en;

  assign smc_valid  = acc_req & ~mis_err;
  assign new_access = smc_valid & ~cfg_sel & ~dis_err;   // SRAM only

  // Capture request; errored beats leave it alone so no SRAM pin moves
  always_ff @(posedge hclk6 or negedge n_sys_reset6)
  begin
    if (!n_sys_reset6)
    begin
      req        <= '0;
      cfg_access <= 1'b0;
    end
    else
    begin
      cfg_access <= smc_valid & cfg_sel;    // One-cycle data phase
      if (smc_valid & ~dis_err)
        req <= '{addr: haddr, size: hsize[1:0], write: hwrite, cfg: cfg_sel};
    end
  end

  // ------------------------------
  // Response
  // ------------------------------
  always_ff @(posedge hclk6 or negedge n_sys_reset6)
  begin
    if (!n_sys_reset6)
    begin
      smc_hresp <= RSP_OKAY;
      r_hresp   <= 1'b0;
    end
    else if (mis_err | dis_err)
    begin
      smc_hresp <= RSP_ERROR;   // First cycle, ready low
      r_hresp   <= 1'b1;
    end
    else if (r_hresp)
    begin
      smc_hresp <= RSP_ERROR;   // Second cycle, ready high
      r_hresp   <= 1'b0;
    end
    else
    begin
      smc_hresp <= RSP_OKAY;
      r_hresp   <= 1'b0;
    end
  end

  // Ready low through SRAM data phase and first ERROR cycle
  always_ff @(posedge hclk6 or negedge n_sys_reset6)
  begin
    if (!n_sys_reset6)
      r_ready <= 1'b1;
    else if (mis_err | dis_err)
      r_ready <= 1'b0;
    else if (new_access)
      r_ready <= 1'b0;
    else if (r_hresp)
      r_ready <= 1'b1;
    else if (!smc_hready)
      r_ready <= r_ready;       // SRAM access still running
    else
      r_ready <= 1'b1;          // Idle, busy, config or not selected
  end

  assign smc_hready = r_ready | (smc_done & mac_done);

  // Read data by space of the current data phase
  assign smc_hrdata = req.cfg ? cfg_rdata : read_data;

endmodule

`default_nettype wire

// File: hw/smc_cfg_regs.sv
// Configuration registers for wait counts and enable; accessed through the AHB front end
`timescale 1ns/1ps
`default_nettype none

`include "smc_config.svh"

module smc_cfg_regs (
  input  logic              hclk6,
  input  logic              n_sys_reset6,
  input  logic              cfg_access,   // Config data phase
  input  smc_pkg::ahb_req_t req,          // Captured address phase
  input  logic [31:0]       hwdata,
  output logic [31:0]       cfg_rdata,
  output smc_pkg::mem_cfg_t cfg
);
  import smc_pkg::*;

  localparam logic [`SMC_WAIT_W-1:0] RD_WAIT_RST = `SMC_RD_WAIT_RST;
  localparam logic [`SMC_WAIT_W-1:0] WR_WAIT_RST = `SMC_WR_WAIT_RST;

  logic [`SMC_WAIT_W-1:0] rd_wait;   // Extra read strobe cycles
  logic [`SMC_WAIT_W-1:0] wr_wait;   // Extra write strobe cycles
  logic                   mem_en;
  logic [1:0]             reg_idx;
  logic                   wr_en;

  assign reg_idx = req.addr[3:2];            // Word index
  assign wr_en   = cfg_access & req.write;

  // ------------------------------
  // Register write
  // ------------------------------
  // hwdata is valid in the data phase, update at its closing edge
  always_ff @(posedge hclk6 or negedge n_sys_reset6)
  begin
    if (!n_sys_reset6)
    begin
      rd_wait <= RD_WAIT_RST;
      wr_wait <= WR_WAIT_RST;
      mem_en  <= 1'b1;          // Enabled out of reset
    end
    else if (wr_en)
    begin
      case (reg_idx)
        2'd0:    rd_wait <= hwdata[`SMC_WAIT_W-1:0];
        2'd1:    wr_wait <= hwdata[`SMC_WAIT_W-1:0];
        2'd2:    mem_en  <= hwdata[0];
        default: ;              // Index 3 unused
      endcase
    end
  end

  // ------------------------------
  // Read back, zero extended
  // ------------------------------
  always_comb
  begin
    cfg_rdata = '0;
    case (reg_idx)
      2'd0:    cfg_rdata[`SMC_WAIT_W-1:0] = rd_wait;
      2'd1:    cfg_rdata[`SMC_WAIT_W-1:0] = wr_wait;
      2'd2:    cfg_rdata[0] = mem_en;
      default: cfg_rdata = '0;
    endcase
  end

  // Settings to the access FSM
  assign cfg = '{rd_wait: rd_wait, wr_wait: wr_wait, mem_en: mem_en};

endmodule

`default_nettype wire

// File: hw/smc_mac.sv
// SRAM access FSM; runs setup, strobe and hold per 16-bit transfer, two transfers for a word
`timescale 1ns/1ps
`default_nettype none

`include "smc_config.svh"

module smc_mac (
  input  logic               hclk6,
  input  logic               n_sys_reset6,
  input  logic               new_access,   // SRAM address phase accepted
  input  smc_pkg::ahb_req_t  req,
  input  smc_pkg::mem_cfg_t  cfg,
  input  logic [31:0]        hwdata,
  input  logic [15:0]        mem_rdata,
  output smc_pkg::mem_pins_t mem,
  output logic [31:0]        read_data,
  output logic               smc_done,
  output logic               mac_done
);
  import smc_pkg::*;

  mac_state_e             state;
  mac_state_e             state_nxt;
  logic [`SMC_WAIT_W-1:0] wait_cnt;    // Strobe cycles left minus one
  logic                   half_cnt;    // 1 on upper half of a word
  logic                   is_word;
  logic                   half_idx;    // Halfword lane in the 32-bit bus
  logic                   strobe_end;

  assign is_word    = (req.size == SZ_WORD[1:0]);
  assign half_idx   = is_word ? half_cnt : req.addr[1];
  assign strobe_end = (state == ST_STROBE) && (wait_cnt == '0);

  assign smc_done = (state == ST_HOLD);
  assign mac_done = (state != ST_IDLE) & (~is_word | half_cnt);   // Last transfer

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:
        if (new_access)
          state_nxt = ST_SETUP;
      ST_SETUP:
        state_nxt = ST_STROBE;
      ST_STROBE:
        if (wait_cnt == '0)
          state_nxt = ST_HOLD;
      ST_HOLD:
        // Upper half of a word, or next beat back to back
        if (~mac_done | new_access)
          state_nxt = ST_SETUP;
        else
          state_nxt = ST_IDLE;
      default:
        state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge hclk6 or negedge n_sys_reset6)
  begin
    if (!n_sys_reset6)
    begin
      state    <= ST_IDLE;
      wait_cnt <= '0;
      half_cnt <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      if (state == ST_SETUP)
        wait_cnt <= req.write ? cfg.wr_wait : cfg.rd_wait;   // Strobe length
      else if ((state == ST_STROBE) && (wait_cnt != '0))
        wait_cnt <= wait_cnt - 1'b1;
      if (state == ST_HOLD)
        half_cnt <= ~mac_done;  // Back to 0 once the access ends
    end
  end

  // ------------------------------
  // Read capture
  // ------------------------------
  // Sample at the last strobe edge, held through hold
  always_ff @(posedge hclk6)
  begin
    if (strobe_end && !req.write)
    begin
      if (half_idx)
        read_data[31:16] <= mem_rdata;
      else
        read_data[15:0] <= mem_rdata;
    end
  end

  // ------------------------------
  // SRAM pins
  // ------------------------------
  always_comb
  begin
    mem.addr  = {req.addr[20:2], half_idx};
    mem.wdata = '0;                            // Quiet while idle
    if (state != ST_IDLE)
      mem.wdata = half_idx ? hwdata[31:16] : hwdata[15:0];
    mem.cs_n  = (state == ST_IDLE);
    mem.oe_n  = ~((state == ST_STROBE) & ~req.write);
    mem.we_n  = ~((state == ST_STROBE) & req.write);
    // Byte picks one lane, halfword and word use both
    if (req.size == SZ_BYTE[1:0])
      mem.be_n = {~req.addr[0], req.addr[0]};
    else
      mem.be_n = 2'b00;
  end

endmodule

`default_nettype wire

// File: hw/smc_pkg.sv
// Types shared by the SRAM controller blocks; compile first, modules import it in their bodies
`default_nettype none

`include "smc_config.svh"

package smc_pkg;

  // ------------------------------
  // AHB encodings
  // ------------------------------
  typedef enum logic [1:0] {
    TRN_IDLE   = 2'b00,
    TRN_BUSY   = 2'b01,
    TRN_NONSEQ = 2'b10,
    TRN_SEQ    = 2'b11
  } htrans_e;

  typedef enum logic [2:0] {
    SZ_BYTE = 3'b000,
    SZ_HALF = 3'b001,
    SZ_WORD = 3'b010    // Largest size this slave handles
  } hsize_e;

  typedef enum logic [1:0] {
    RSP_OKAY  = 2'b00,
    RSP_ERROR = 2'b01   // Always given as a two-cycle response
  } hresp_e;

  // Access FSM, one pass per 16-bit transfer
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_SETUP  = 2'd1,
    ST_STROBE = 2'd2,
    ST_HOLD   = 2'd3
  } mac_state_e;

  // ------------------------------
  // Structs between blocks
  // ------------------------------
  typedef struct packed {
    logic [31:0] addr;   // Byte address from haddr
    logic [1:0]  size;   // Low bits of hsize
    logic        write;
    logic        cfg;    // Config space access
  } ahb_req_t;

  typedef struct packed {
    logic [`SMC_WAIT_W-1:0] rd_wait;
    logic [`SMC_WAIT_W-1:0] wr_wait;
    logic                   mem_en;   // Low blocks SRAM space with ERROR
  } mem_cfg_t;

  // SRAM pins, all strobes active low
  typedef struct packed {
    logic [19:0] addr;    // Halfword address
    logic [15:0] wdata;
    logic        cs_n;
    logic        oe_n;
    logic        we_n;
    logic [1:0]  be_n;    // [0] low byte, [1] high byte
  } mem_pins_t;

endpackage

`default_nettype wire

// File: hw/smc_top.sv
// Top of the static memory controller; AHB-lite slave port in, 16-bit SRAM pins out
`timescale 1ns/1ps
`default_nettype none

module smc_top (
  input  logic               hclk6,
  input  logic               n_sys_reset6,
  // AHB slave port
  input  logic               hsel,
  input  logic [31:0]        haddr,
  input  smc_pkg::htrans_e   htrans,
  input  logic               hwrite,
  input  smc_pkg::hsize_e    hsize,
  input  logic [31:0]        hwdata,
  input  logic               hready,
  output logic [31:0]        smc_hrdata,
  output logic               smc_hready,
  output smc_pkg::hresp_e    smc_hresp,
  output logic               smc_valid,
  // SRAM side
  input  logic [15:0]        mem_rdata,
  output smc_pkg::mem_pins_t mem
);
  import smc_pkg::*;

  ahb_req_t    req;           // Captured address phase
  mem_cfg_t    cfg;           // Wait counts and enable
  logic        new_access;
  logic        cfg_access;
  logic        smc_done;
  logic        mac_done;
  logic [31:0] read_data;     // Assembled SRAM read
  logic [31:0] cfg_rdata;     // Register read back

  // ------------------------------
  // Bus front end
  // ------------------------------
  smc_ahb_if u_ahb_if (
    .hclk6       (hclk6),
    .n_sys_reset6(n_sys_reset6),
    .hsel        (hsel),
    .haddr       (haddr),
    .htrans      (htrans),
    .hwrite      (hwrite),
    .hsize       (hsize),
    .hready      (hready),
    .mem_en      (cfg.mem_en),
    .smc_done    (smc_done),
    .mac_done    (mac_done),
    .read_data   (read_data),
    .cfg_rdata   (cfg_rdata),
    .smc_hrdata  (smc_hrdata),
    .smc_hready  (smc_hready),
    .smc_hresp   (smc_hresp),
    .smc_valid   (smc_valid),
    .new_access  (new_access),
    .cfg_access  (cfg_access),
    .req         (req)
  );

  smc_cfg_regs u_cfg_regs (
    .hclk6       (hclk6),
    .n_sys_reset6(n_sys_reset6),
    .cfg_access  (cfg_access),
    .req         (req),
    .hwdata      (hwdata),
    .cfg_rdata   (cfg_rdata),
    .cfg         (cfg)
  );

  // ------------------------------
  // SRAM sequencing
  // ------------------------------
  smc_mac u_mac (
    .hclk6       (hclk6),
    .n_sys_reset6(n_sys_reset6),
    .new_access  (new_access),
    .req         (req),
    .cfg         (cfg),
    .hwdata      (hwdata),
    .mem_rdata   (mem_rdata),
    .mem         (mem),
    .read_data   (read_data),
    .smc_done    (smc_done),
    .mac_done    (mac_done)
  );

endmodule

`default_nettype wire

// File: include/smc_config.svh
// Build constants for the SRAM controller; include in RTL and testbench files that need them
`ifndef SMC_CONFIG_SVH
`define SMC_CONFIG_SVH

// ------------------------------
// Address decode
// ------------------------------
// haddr bit set -> configuration space, clear -> SRAM space
`define SMC_CFG_SEL_BIT 16

// ------------------------------
// Wait states
// ------------------------------
`define SMC_WAIT_W      4    // Bits per wait count
`define SMC_RD_WAIT_RST 2    // Read strobe extension out of reset
`define SMC_WR_WAIT_RST 1    // Write strobe extension out of reset

`endif

// File: tb.f
+incdir+include
hw/smc_pkg.sv
hw/smc_ahb_if.sv
hw/smc_cfg_regs.sv
hw/smc_mac.sv
hw/smc_top.sv
tb/smc_sram_model.sv
tb/smc_checker.sv
tb/tb_smc.sv

// File: tb/smc_checker.sv
// Protocol assertions on the controller ports; attached to every smc_top by the bind at the end
`timescale 1ns/1ps
`default_nettype none

module smc_checker (
  input logic               hclk6,
  input logic               n_sys_reset6,
  input logic               hsel,
  input smc_pkg::htrans_e   htrans,
  input logic               hready,
  input logic               smc_hready,
  input smc_pkg::hresp_e    smc_hresp,
  input smc_pkg::mem_pins_t mem
);
  import smc_pkg::*;

  int fail_cnt = 0;   // Failed assertions so far

  // ------------------------------
  // AHB response
  // ------------------------------
  err_two_cycle: assert property (@(posedge hclk6) disable iff (!n_sys_reset6)
    (smc_hresp == RSP_ERROR) && !smc_hready |=> (smc_hresp == RSP_ERROR) && smc_hready)
  else
  begin
    $error("ERROR response without its second cycle with ready high");
    fail_cnt++;
  end

  // Selected IDLE or BUSY gets a zero wait OKAY
  idle_one_cycle: assert property (@(posedge hclk6) disable iff (!n_sys_reset6)
    hsel && hready && ((htrans == TRN_IDLE) || (htrans == TRN_BUSY))
      |=> smc_hready && (smc_hresp == RSP_OKAY))
  else
  begin
    $error("Selected IDLE or BUSY transfer not completed in one cycle");
    fail_cnt++;
  end

  ready_after_reset: assert property (@(posedge hclk6)
    !n_sys_reset6 |=> smc_hready && (smc_hresp == RSP_OKAY))
  else
  begin
    $error("Bus not ready with OKAY out of reset");
    fail_cnt++;
  end

  // ------------------------------
  // SRAM strobes
  // ------------------------------
  pins_after_reset: assert property (@(posedge hclk6)
    !n_sys_reset6 |=> mem.cs_n && mem.oe_n && mem.we_n)
  else
  begin
    $error("SRAM strobes active in reset");
    fail_cnt++;
  end

  oe_we_exclusive: assert property (@(posedge hclk6) disable iff (!n_sys_reset6)
    !(!mem.oe_n && !mem.we_n))
  else
  begin
    $error("Output enable and write enable both low");
    fail_cnt++;
  end

endmodule

bind smc_top smc_checker u_checker (
  .hclk6       (hclk6),
  .n_sys_reset6(n_sys_reset6),
  .hsel        (hsel),
  .htrans      (htrans),
  .hready      (hready),
  .smc_hready  (smc_hready),
  .smc_hresp   (smc_hresp),
  .mem         (mem)
);

`default_nettype wire

// File: tb/smc_sram_model.sv
// Behavioural 16-bit asynchronous SRAM with byte enables; the testbench hangs it on the SRAM pins
`timescale 1ns/1ps
`default_nettype none

module smc_sram_model (
  input  smc_pkg::mem_pins_t mem,
  output logic [15:0]        mem_rdata
);

  logic [15:0] words [logic [19:0]];   // Written halfwords only
  logic [15:0] merged;                 // Halfword after lane merge

  // Unwritten contents, every address bit takes part
  function automatic logic [15:0] fill_half(input logic [19:0] a);
    return a[15:0] ^ {a[19:16], a[19:16], a[19:16], a[19:16]} ^ 16'h5a3c;
  endfunction

  function automatic logic [15:0] stored_half(input logic [19:0] a);
    if (words.exists(a))
      return words[a];
    return fill_half(a);
  endfunction

  // ------------------------------
  // Write at the trailing edge of we_n
  // ------------------------------
  always @(posedge mem.we_n)
  begin
    if (mem.cs_n == 1'b0)
    begin
      merged = stored_half(mem.addr);
      if (!mem.be_n[0])
        merged[7:0] = mem.wdata[7:0];     // Low byte lane
      if (!mem.be_n[1])
        merged[15:8] = mem.wdata[15:8];   // High byte lane
      words[mem.addr] = merged;
    end
  end

  // Read path, released while deselected
  always_comb
  begin
    if (!mem.cs_n && !mem.oe_n)
      mem_rdata = stored_half(mem.addr);
    else
      mem_rdata = 'z;
  end

endmodule

`default_nettype wire

// File: tb/tb_smc.sv
// Testbench top for the SRAM controller; runs AHB transfers against a byte shadow of the SRAM
`timescale 1ns/1ps
`default_nettype none

`include "smc_config.svh"

module tb_smc;
  import smc_pkg::*;

  localparam int          XFER_TIMEOUT = 100;   // Data phase cycles before giving up
  localparam logic [31:0] CFG_BASE     = 32'h1 << `SMC_CFG_SEL_BIT;

  logic        hclk6;
  logic        n_sys_reset6;
  logic        hsel;
  logic [31:0] haddr;
  htrans_e     htrans;
  logic        hwrite;
  hsize_e      hsize;
  logic [31:0] hwdata;
  logic        hready;
  logic [31:0] smc_hrdata;
  logic        smc_hready;
  hresp_e      smc_hresp;
  logic        smc_valid;
  logic [15:0] mem_rdata;
  mem_pins_t   mem;

  // Expected state
  logic [7:0]             shadow [logic [31:0]];   // Byte address to byte
  logic [`SMC_WAIT_W-1:0] rd_wait_m;
  logic [`SMC_WAIT_W-1:0] wr_wait_m;
  logic                   mem_en_m;
  logic [31:0]            lfsr_q;
  int                     err_cnt;
  int                     test_err_base;
  int                     tests_run;
  int                     tests_failed;
  bit                     timed_out;

  assign hready = smc_hready;   // Only slave on the bus

  smc_top DUT (
    .hclk6       (hclk6),
    .n_sys_reset6(n_sys_reset6),
    .hsel        (hsel),
    .haddr       (haddr),
    .htrans      (htrans),
    .hwrite      (hwrite),
    .hsize       (hsize),
    .hwdata      (hwdata),
    .hready      (hready),
    .smc_hrdata  (smc_hrdata),
    .smc_hready  (smc_hready),
    .smc_hresp   (smc_hresp),
    .smc_valid   (smc_valid),
    .mem_rdata   (mem_rdata),
    .mem         (mem)
  );

  smc_sram_model u_sram (
    .mem      (mem),
    .mem_rdata(mem_rdata)
  );

  initial
  begin
    hclk6 = 1'b0;
    forever #10 hclk6 = ~hclk6;   // 20 ns period
  end

  // ------------------------------
  // Random numbers
  // ------------------------------
  // Fibonacci LFSR x^32+x^22+x^2+x+1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    int          i;
    val = '0;
    for (i = 0; i < n; i++)
    begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  // Word aligned, always in SRAM space
  function automatic logic [31:0] rand_word_addr();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = rand_bits(4);
    lo = rand_bits(15);
    return {11'h0, hi[3:0], lo[14:0], 2'b00} & ~CFG_BASE;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input logic [31:0] mask, input string what);
    assert ((got & mask) == (exp & mask))
    else
    begin
      $display("CHECK FAILED at %0d ns: %s %h, expected %h", $time, what, got & mask,
               exp & mask);
      err_cnt++;
    end
  endtask

  // ------------------------------
  // Bus transfer
  // ------------------------------
  // Entered 2 ns after an edge with the bus ready, returns the same way
  task automatic ahb_xfer(input logic [31:0] addr, input htrans_e trn, input hsize_e size,
                          input logic write, input logic [31:0] wdata, input logic exp_valid,
                          input hresp_e exp_resp, input int exp_cycles,
                          input logic [31:0] exp_rdata, input logic [31:0] rd_mask);
    int   cycles;
    logic done;
    if (timed_out)
      return;
    hsel   = 1'b1;
    haddr  = addr;
    htrans = trn;
    hwrite = write;
    hsize  = size;
    @(negedge hclk6);              // Address decode settled
    assert (smc_valid == exp_valid)
    else
    begin
      $display("CHECK FAILED at %0d ns: smc_valid %b at %h, expected %b",
               $time, smc_valid, addr, exp_valid);
      err_cnt++;
    end
    @(posedge hclk6);              // Address phase taken
    #2;
    hsel   = 1'b0;
    htrans = TRN_IDLE;
    hwdata = wdata;                // Held for the whole data phase
    cycles = 0;
    done   = 1'b0;
    while (!done && (cycles < XFER_TIMEOUT))
    begin
      @(negedge hclk6);            // Outputs settled
      cycles++;
      assert (smc_hresp == exp_resp)
      else
      begin
        $display("CHECK FAILED at %0d ns: %s in data phase cycle %0d at %h, expected %s",
                 $time, smc_hresp.name(), cycles, addr, exp_resp.name());
        err_cnt++;
      end
      if (smc_hready)
      begin
        done = 1'b1;
        check_value(smc_hrdata, exp_rdata, rd_mask, "read data");
      end
      @(posedge hclk6);
      #2;
    end
    if (!done)
    begin
      $display("Timeout at %0d ns: data phase at %h still not ready after %0d cycles",
               $time, addr, XFER_TIMEOUT);
      timed_out = 1'b1;
    end
    else
    begin
      assert (cycles == exp_cycles)
      else
      begin
        $display("CHECK FAILED at %0d ns: data phase at %h took %0d cycles, expected %0d",
                 $time, addr, cycles, exp_cycles);
        err_cnt++;
      end
    end
  endtask

  // SRAM space access, expectations from shadow and wait counts
  task automatic mem_access(input logic [31:0] addr, input hsize_e size, input logic write,
                            input logic [31:0] wdata);
    int          nbytes;
    int          wait_n;
    int          k;
    int          lane;
    logic        misaligned;
    logic [31:0] exp_rdata;
    logic [31:0] mask;
    nbytes     = (size == SZ_WORD) ? 4 : ((size == SZ_HALF) ? 2 : 1);
    misaligned = ((size == SZ_HALF) && addr[0]) || ((size == SZ_WORD) && (addr[1:0] != 2'b00));
    wait_n     = write ? int'(wr_wait_m) : int'(rd_wait_m);
    exp_rdata  = '0;
    mask       = '0;
    if (misaligned || !mem_en_m)
      ahb_xfer(addr, TRN_NONSEQ, size, write, wdata, !misaligned, RSP_ERROR, 2, '0, '0);
    else
    begin
      for (k = 0; k < nbytes; k++)
      begin
        lane = int'(addr[1:0]) + k;       // Little-endian byte lane
        if (!write && shadow.exists(addr + k))
        begin
          exp_rdata[8*lane +: 8] = shadow[addr + k];
          mask[8*lane +: 8]      = 8'hff;
        end
      end
      ahb_xfer(addr, TRN_NONSEQ, size, write, wdata, 1'b1, RSP_OKAY,
               (nbytes / 4 + 1) * (wait_n + 3), exp_rdata, mask);
      if (write)
      begin
        for (k = 0; k < nbytes; k++)
        begin
          lane = int'(addr[1:0]) + k;
          shadow[addr + k] = wdata[8*lane +: 8];
        end
      end
    end
  endtask

  task automatic write_cfg(input int idx, input logic [31:0] val);
    ahb_xfer(CFG_BASE | (32'(idx) << 2), TRN_NONSEQ, SZ_WORD, 1'b1, val, 1'b1, RSP_OKAY, 1,
             '0, '0);
    case (idx)
      0:       rd_wait_m = val[`SMC_WAIT_W-1:0];
      1:       wr_wait_m = val[`SMC_WAIT_W-1:0];
      2:       mem_en_m  = val[0];
      default: ;                    // Index 3 holds nothing
    endcase
  endtask

  task automatic read_cfg(input int idx);
    logic [31:0] exp;
    case (idx)
      0:       exp = 32'(rd_wait_m);
      1:       exp = 32'(wr_wait_m);
      2:       exp = 32'(mem_en_m);
      default: exp = '0;
    endcase
    ahb_xfer(CFG_BASE | (32'(idx) << 2), TRN_NONSEQ, SZ_WORD, 1'b0, '0, 1'b1, RSP_OKAY, 1,
             exp, 32'hffff_ffff);
  endtask

  task automatic idle_xfer(input htrans_e trn);
    ahb_xfer(rand_word_addr(), trn, SZ_WORD, 1'b0, '0, 1'b0, RSP_OKAY, 1, '0, '0);
  endtask

  task automatic finish_test(input string name);
    int n;
    n = err_cnt - test_err_base;
    tests_run++;
    if ((n != 0) || timed_out)
      tests_failed++;
    $display("%s: %s, %0d errors", name, ((n != 0) || timed_out) ? "failed" : "passed", n);
    test_err_base = err_cnt;
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic word_rw_test();
    logic [31:0] addrs [$];
    int          i;
    for (i = 0; i < 8; i++)
    begin
      addrs.push_back(rand_word_addr());
      mem_access(addrs[i], SZ_WORD, 1'b1, rand_bits(32));
    end
    for (i = 0; i < addrs.size(); i++)
      mem_access(addrs[i], SZ_WORD, 1'b0, '0);
    finish_test("random word write and read");
  endtask

  task automatic narrow_test();
    logic [31:0] base;
    int          i;
    base = rand_word_addr();
    mem_access(base, SZ_WORD, 1'b1, rand_bits(32));        // Known word
    mem_access(base + 1, SZ_BYTE, 1'b1, rand_bits(32));
    mem_access(base + 2, SZ_HALF, 1'b1, rand_bits(32));
    mem_access(base, SZ_WORD, 1'b0, '0);                   // Merged lanes
    for (i = 0; i < 4; i++)
      mem_access(base + i, SZ_BYTE, 1'b0, '0);
    mem_access(base, SZ_HALF, 1'b0, '0);
    mem_access(base + 2, SZ_HALF, 1'b0, '0);
    mem_access(base + 3, SZ_BYTE, 1'b1, rand_bits(32));
    mem_access(base, SZ_HALF, 1'b1, rand_bits(32));
    mem_access(base, SZ_WORD, 1'b0, '0);
    finish_test("byte and halfword lanes");
  endtask

  task automatic misalign_test();
    logic [31:0] base;
    base = rand_word_addr();
    mem_access(base, SZ_WORD, 1'b1, rand_bits(32));
    mem_access(base + 1, SZ_HALF, 1'b1, rand_bits(32));    // ERROR
    mem_access(base + 2, SZ_WORD, 1'b1, rand_bits(32));    // ERROR
    mem_access(base + 3, SZ_WORD, 1'b0, '0);               // ERROR
    mem_access(base + 3, SZ_HALF, 1'b0, '0);               // ERROR
    mem_access(base, SZ_WORD, 1'b0, '0);                   // Still the first word
    finish_test("misaligned accesses");
  endtask

  task automatic cfg_test();
    logic [31:0] a;
    int          i;
    int          r;
    for (r = 0; r < 4; r++)
      read_cfg(r);                                         // Reset values
    for (i = 0; i < 3; i++)
    begin
      write_cfg(0, rand_bits(32));
      write_cfg(1, rand_bits(32));
      write_cfg(3, rand_bits(32));
      for (r = 0; r < 4; r++)
        read_cfg(r);
      a = rand_word_addr();
      mem_access(a, SZ_WORD, 1'b1, rand_bits(32));
      mem_access(a, SZ_WORD, 1'b0, '0);
      mem_access(a + 2, SZ_BYTE, 1'b1, rand_bits(32));
      mem_access(a + 2, SZ_HALF, 1'b0, '0);
    end
    write_cfg(0, 32'h0);                                    // Shortest strobe
    write_cfg(1, 32'h0);
    mem_access(a, SZ_WORD, 1'b1, rand_bits(32));
    mem_access(a, SZ_WORD, 1'b0, '0);
    finish_test("config registers and wait states");
  endtask

  task automatic disable_test();
    logic [31:0] a;
    a = rand_word_addr();
    mem_access(a, SZ_WORD, 1'b1, rand_bits(32));
    write_cfg(2, 32'h0);
    read_cfg(2);
    read_cfg(0);
    mem_access(a, SZ_WORD, 1'b0, '0);                      // ERROR while disabled
    mem_access(a + 1, SZ_BYTE, 1'b1, rand_bits(32));       // ERROR, SRAM untouched
    idle_xfer(TRN_IDLE);
    idle_xfer(TRN_BUSY);
    write_cfg(1, 32'h3);
    read_cfg(1);
    write_cfg(2, 32'h1);
    read_cfg(2);
    mem_access(a, SZ_WORD, 1'b0, '0);
    mem_access(a + 1, SZ_BYTE, 1'b1, rand_bits(32));
    mem_access(a, SZ_WORD, 1'b0, '0);
    idle_xfer(TRN_BUSY);
    idle_xfer(TRN_IDLE);
    finish_test("controller disable and idle");
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial
  begin
    int t;
    lfsr_q        = 32'h39cc_babe;
    n_sys_reset6  = 1'b0;
    hsel          = 1'b0;
    haddr         = '0;
    htrans        = TRN_IDLE;
    hwrite        = 1'b0;
    hsize         = SZ_WORD;
    hwdata        = '0;
    rd_wait_m     = `SMC_RD_WAIT_RST;
    wr_wait_m     = `SMC_WR_WAIT_RST;
    mem_en_m      = 1'b1;
    err_cnt       = 0;
    test_err_base = 0;
    tests_run     = 0;
    tests_failed  = 0;
    timed_out     = 1'b0;
    repeat (16) @(posedge hclk6);
    #2;
    n_sys_reset6 = 1'b1;
    @(posedge hclk6);
    #2;
    for (t = 1; (t <= 5) && !timed_out; t++)
    begin
      case (t)
        1:       word_rw_test();
        2:       narrow_test();
        3:       misalign_test();
        4:       cfg_test();
        default: disable_test();
      endcase
    end
    $display("Summary: %0d tests run, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, tests_failed, err_cnt, DUT.u_checker.fail_cnt);
    if ((err_cnt == 0) && (tests_failed == 0) && !timed_out &&
        (DUT.u_checker.fail_cnt == 0))
    begin
      $display("TEST RESULT: PASS");
    end
    else
    begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
